// ==== src/bp_geometry_pkg.sv ====
package bp_geometry_pkg;

    ////////////////////////////////////////////////////////////
    // fetch address
    ////////////////////////////////////////////////////////////

    localparam int pc_width = 32;
    // sequential fetch step, one 32-bit instruction
    localparam int inst_bytes = 4;

    ////////////////////////////////////////////////////////////
    // history and pattern tables
    ////////////////////////////////////////////////////////////

    // index field skips the byte offset, bits 9..2
    localparam int idx_lsb = 2;
    localparam int idx_width = 8;
    localparam int hist_width = 8;
    localparam int hist_entries = 256;
    localparam int pattern_entries = 256;

    ////////////////////////////////////////////////////////////
    // branch target buffer
    ////////////////////////////////////////////////////////////

    // direct mapped, 64 entries, index bits 7..2
    localparam int btb_idx_lsb = 2;
    localparam int btb_idx_width = 6;
    localparam int btb_entries = 1 << btb_idx_width;
    // tag covers everything above the index, bits 31..8
    localparam int btb_tag_lsb = 8;
    localparam int btb_tag_width = pc_width - btb_tag_lsb;

endpackage

// ==== src/bp_types_pkg.sv ====
package bp_types_pkg;

    // two-bit direction counter, upper bit is the prediction
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt = 2'b01;
    localparam ctr_t ctr_weak_t = 2'b10;
    localparam ctr_t ctr_strong_t = 2'b11;

    typedef logic [bp_geometry_pkg::hist_width-1:0] hist_t;
    typedef logic [bp_geometry_pkg::pc_width-1:0] pc_t;

    // stage 1 payload
    typedef struct packed {
        pc_t   pc;
        hist_t hist;
    } lookup_t;

    // stage 2 payload, what fetch sees
    typedef struct packed {
        pc_t  pc;
        logic taken;
        pc_t  next_pc;
    } pred_t;

    function automatic logic ctr_taken(ctr_t ctr);
        return ctr[1];
    endfunction

    // one step toward the outcome, saturating at both ends
    function automatic ctr_t ctr_next(ctr_t ctr, logic taken);
        ctr_t nxt;
        case (ctr)
            ctr_strong_nt: nxt = taken ? ctr_weak_nt : ctr_strong_nt;
            ctr_weak_nt:   nxt = taken ? ctr_weak_t : ctr_strong_nt;
            ctr_weak_t:    nxt = taken ? ctr_strong_t : ctr_weak_nt;
            ctr_strong_t:  nxt = taken ? ctr_strong_t : ctr_weak_t;
            default:       nxt = ctr;
        endcase
        return nxt;
    endfunction

endpackage

// ==== src/pipe_stage_reg.sv ====
`timescale 1ns/100ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    // upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // room when empty or when the held item leaves this cycle
    assign in_ready = !full || out_ready;

    // occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            // refill or drain in the same edge
            full <= in_valid;
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data = data_q;

endmodule

// ==== src/branch_history_table.sv ====
`timescale 1ns/100ps

module branch_history_table (
    input  logic                clk,
    input  logic                rst,

    // fetch side lookup
    input  bp_types_pkg::pc_t   lookup_pc,
    output bp_types_pkg::hist_t lookup_hist,

    // resolve side
    input  logic                update_valid,
    input  bp_types_pkg::pc_t   update_pc,
    input  logic                update_taken,
    output bp_types_pkg::hist_t update_hist
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // one shift register per branch slot
    bp_types_pkg::hist_t hist_mem [bp_geometry_pkg::hist_entries];

    logic [bp_geometry_pkg::idx_width-1:0] lookup_idx;
    logic [bp_geometry_pkg::idx_width-1:0] update_idx;

    // address bits 9..2 pick the slot
    assign lookup_idx = lookup_pc[bp_geometry_pkg::idx_lsb +: bp_geometry_pkg::idx_width];
    assign update_idx = update_pc[bp_geometry_pkg::idx_lsb +: bp_geometry_pkg::idx_width];

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // both combinational
    assign lookup_hist = hist_mem[lookup_idx];

    // pre-shift value, the pattern table trains on this one
    assign update_hist = hist_mem[update_idx];

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // all histories start at zero
            for (int i = 0; i < bp_geometry_pkg::hist_entries; i++) begin
                hist_mem[i] <= '0;
            end
        end else if (update_valid) begin
            // oldest outcome drops off the top, newest enters at bit 0
            hist_mem[update_idx] <= {
                update_hist[bp_geometry_pkg::hist_width-2:0],
                update_taken
            };
        end
    end

endmodule

// ==== src/pattern_counter_table.sv ====
`timescale 1ns/100ps

module pattern_counter_table (
    input  logic                clk,
    input  logic                rst,

    // lookup from the stage 1 register
    input  bp_types_pkg::pc_t   lookup_pc,
    input  bp_types_pkg::hist_t lookup_hist,
    output logic                lookup_taken,

    // resolve side, history is the pre-shift value
    input  logic                update_valid,
    input  bp_types_pkg::pc_t   update_pc,
    input  bp_types_pkg::hist_t update_hist,
    input  logic                update_taken
);

    ////////////////////////////////////////////////////////////
    // storage and indexing
    ////////////////////////////////////////////////////////////

    bp_types_pkg::ctr_t ctr_mem [bp_geometry_pkg::pattern_entries];

    logic [bp_geometry_pkg::idx_width-1:0] lookup_pc_idx;
    logic [bp_geometry_pkg::idx_width-1:0] update_pc_idx;
    logic [bp_geometry_pkg::idx_width-1:0] lookup_idx;
    logic [bp_geometry_pkg::idx_width-1:0] update_idx;

    // address index field, same bits as the history table
    assign lookup_pc_idx = lookup_pc[bp_geometry_pkg::idx_lsb +: bp_geometry_pkg::idx_width];
    assign update_pc_idx = update_pc[bp_geometry_pkg::idx_lsb +: bp_geometry_pkg::idx_width];

    // history hashed with address, flat 256-entry table
    assign lookup_idx = lookup_hist ^ lookup_pc_idx;
    assign update_idx = update_hist ^ update_pc_idx;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    // taken on weak_t or strong_t
    assign lookup_taken = bp_types_pkg::ctr_taken(ctr_mem[lookup_idx]);

    ////////////////////////////////////////////////////////////
    // training
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // every counter starts strongly not taken
            for (int i = 0; i < bp_geometry_pkg::pattern_entries; i++) begin
                ctr_mem[i] <= bp_types_pkg::ctr_strong_nt;
            end
        end else if (update_valid) begin
            // one step toward the resolved outcome
            ctr_mem[update_idx] <= bp_types_pkg::ctr_next(
                ctr_mem[update_idx],
                update_taken
            );
        end
    end

endmodule

// ==== src/branch_target_buffer.sv ====
`timescale 1ns/100ps

module branch_target_buffer (
    input  logic              clk,
    input  logic              rst,

    // lookup from the stage 1 register
    input  bp_types_pkg::pc_t lookup_pc,
    output logic              lookup_hit,
    output bp_types_pkg::pc_t lookup_target,

    // resolve side
    input  logic              update_valid,
    input  bp_types_pkg::pc_t update_pc,
    input  logic              update_taken,
    input  bp_types_pkg::pc_t update_target
);

    ////////////////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////////////////

    logic [bp_geometry_pkg::btb_entries-1:0]   entry_valid;
    logic [bp_geometry_pkg::btb_tag_width-1:0] tag_mem    [bp_geometry_pkg::btb_entries];
    bp_types_pkg::pc_t                         target_mem [bp_geometry_pkg::btb_entries];

    logic [bp_geometry_pkg::btb_idx_width-1:0] lookup_idx;
    logic [bp_geometry_pkg::btb_idx_width-1:0] update_idx;
    logic [bp_geometry_pkg::btb_tag_width-1:0] lookup_tag;
    logic [bp_geometry_pkg::btb_tag_width-1:0] update_tag;
    logic                                      write_en;

    // index bits 7..2, tag bits 31..8
    assign lookup_idx = lookup_pc[bp_geometry_pkg::btb_idx_lsb +: bp_geometry_pkg::btb_idx_width];
    assign update_idx = update_pc[bp_geometry_pkg::btb_idx_lsb +: bp_geometry_pkg::btb_idx_width];
    assign lookup_tag = lookup_pc[bp_geometry_pkg::pc_width-1:bp_geometry_pkg::btb_tag_lsb];
    assign update_tag = update_pc[bp_geometry_pkg::pc_width-1:bp_geometry_pkg::btb_tag_lsb];

    // only taken resolves allocate
    assign write_en = update_valid && update_taken;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    // alias in the same slot misses on tag
    assign lookup_hit = entry_valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign lookup_target = target_mem[lookup_idx];

    ////////////////////////////////////////////////////////////
    // write
    ////////////////////////////////////////////////////////////

    // valid bits, cleared only by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (write_en) begin
            entry_valid[update_idx] <= 1'b1;
        end
    end

    // tag and target, overwrite on every taken resolve
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[update_idx] <= update_tag;
            target_mem[update_idx] <= update_target;
        end
    end

endmodule

// ==== src/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor (
    input  logic              clk,
    input  logic              rst,

    // fetch request
    input  logic              req_valid,
    output logic              req_ready,
    input  bp_types_pkg::pc_t req_pc,

    // prediction back to fetch
    output logic              pred_valid,
    input  logic              pred_ready,
    output bp_types_pkg::pc_t pred_pc,
    output logic              pred_taken,
    output bp_types_pkg::pc_t pred_next_pc,

    // resolve from the back end, never stalled
    input  logic              update_valid,
    input  bp_types_pkg::pc_t update_pc,
    input  logic              update_taken,
    input  bp_types_pkg::pc_t update_target
);

    bp_types_pkg::hist_t   lookup_hist;
    bp_types_pkg::hist_t   update_hist;
    bp_types_pkg::lookup_t s1_in;
    bp_types_pkg::lookup_t s1_out;
    logic                  s1_valid;
    logic                  s2_ready;
    logic                  dir_taken;
    logic                  btb_hit;
    bp_types_pkg::pc_t     btb_target;
    bp_types_pkg::pc_t     seq_pc;
    bp_types_pkg::pred_t   s2_in;
    bp_types_pkg::pred_t   s2_out;

    ////////////////////////////////////////////////////////////
    // stage 1: history read
    ////////////////////////////////////////////////////////////

    branch_history_table u_bht (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc    (req_pc),
        .lookup_hist  (lookup_hist),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .update_hist  (update_hist)
    );

    assign s1_in = '{pc: req_pc, hist: lookup_hist};

    pipe_stage_reg #(.payload_t(bp_types_pkg::lookup_t)) u_stage1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (s1_in),
        .out_valid (s1_valid),
        .out_ready (s2_ready),
        .out_data  (s1_out)
    );

    ////////////////////////////////////////////////////////////
    // stage 2: counter and target read, next address
    ////////////////////////////////////////////////////////////

    // trained with the pre-shift history from the bht
    pattern_counter_table u_pct (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc    (s1_out.pc),
        .lookup_hist  (s1_out.hist),
        .lookup_taken (dir_taken),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_hist  (update_hist),
        .update_taken (update_taken)
    );

    branch_target_buffer u_btb (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (s1_out.pc),
        .lookup_hit    (btb_hit),
        .lookup_target (btb_target),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    // fall-through address
    assign seq_pc = s1_out.pc + bp_types_pkg::pc_t'(bp_geometry_pkg::inst_bytes);

    always_comb begin
        s2_in.pc = s1_out.pc;
        // direction only, a redirect also needs a btb hit
        s2_in.taken = dir_taken;
        s2_in.next_pc = (dir_taken && btb_hit) ? btb_target : seq_pc;
    end

    pipe_stage_reg #(.payload_t(bp_types_pkg::pred_t)) u_stage2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .in_ready  (s2_ready),
        .in_data   (s2_in),
        .out_valid (pred_valid),
        .out_ready (pred_ready),
        .out_data  (s2_out)
    );

    // unpack toward fetch
    assign pred_pc = s2_out.pc;
    assign pred_taken = s2_out.taken;
    assign pred_next_pc = s2_out.next_pc;

endmodule

// ==== bench/branch_predictor_assertions.sv ====
`timescale 1ns/100ps

module branch_predictor_assertions (
    input logic              clk,
    input logic              rst,
    input logic              req_ready,
    input logic              s1_valid,
    input logic              pred_valid,
    input logic              pred_ready,
    input bp_types_pkg::pc_t pred_pc,
    input logic              pred_taken,
    input bp_types_pkg::pc_t pred_next_pc
);

    // failed assertions so far
    int failures = 0;

    // output register empty once reset has been seen
    reset_clears: assert property (@(posedge clk) rst |=> !pred_valid)
        else begin
            failures++;
            $error("pred_valid high in the cycle after reset");
        end

    // stalled prediction holds valid and all of its fields
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        pred_valid && !pred_ready |=> pred_valid && $stable(pred_pc)
            && $stable(pred_taken) && $stable(pred_next_pc))
        else begin
            failures++;
            $error("prediction changed or dropped while stalled");
        end

    // empty stage 1 always takes a request
    empty_ready: assert property (@(posedge clk) disable iff (rst) !s1_valid |-> req_ready)
        else begin
            failures++;
            $error("req_ready low with stage 1 empty");
        end

endmodule

// ==== bench/tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor;

    localparam int rand_resolves = 100;
    localparam int rand_lookups = 200;
    localparam int burst_len = 8;
    // a and b share history slot and btb slot, tags differ
    localparam bp_types_pkg::pc_t pc_a = 32'h0000_1040;
    localparam bp_types_pkg::pc_t pc_b = 32'h0000_1440;
    localparam bp_types_pkg::pc_t tgt_a = 32'h0000_3000;
    // slot 0xef with zero history, lands on the counter a uses at history 0xff
    localparam bp_types_pkg::pc_t pc_e = 32'h0000_03bc;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    bp_types_pkg::pc_t req_pc;
    logic pred_valid;
    logic pred_ready;
    bp_types_pkg::pc_t pred_pc;
    logic pred_taken;
    bp_types_pkg::pc_t pred_next_pc;
    logic update_valid;
    bp_types_pkg::pc_t update_pc;
    logic update_taken;
    bp_types_pkg::pc_t update_target;

    // stimulus table, one entry per row
    logic row_lookup [$];
    string row_name [$];
    bp_types_pkg::pc_t row_pc [$];
    logic row_flag [$];
    bp_types_pkg::pc_t row_addr [$];

    // outstanding predictions, oldest first
    string exp_name [$];
    bp_types_pkg::pc_t exp_pc [$];
    logic exp_taken [$];
    bp_types_pkg::pc_t exp_next [$];
    int exp_cycle [$];

    // reference copy of the three tables
    bp_types_pkg::hist_t m_hist [256];
    bp_types_pkg::ctr_t m_ctr [256];
    logic m_valid [64];
    bp_types_pkg::pc_t m_branch [64];
    bp_types_pkg::pc_t m_target [64];

    logic [31:0] addr_state = 32'hf4d7;
    logic [31:0] ready_state = 32'hf4d7;
    logic ready_held = 1'b1;
    int cycle = 0;
    int checks = 0;
    int errors = 0;
    int limit_cycles = 0;

    branch_predictor dut (.*);

    bind branch_predictor branch_predictor_assertions u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // fetch side back-pressure, 3 in 4 ready when random
    always @(posedge clk) begin
        #1;
        ready_state = xorshift(ready_state);
        pred_ready = ready_held || (ready_state[1:0] != 2'b00);
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_row(input logic lookup, input string name, input bp_types_pkg::pc_t pc,
                           input logic flag, input bp_types_pkg::pc_t addr);
        row_lookup.push_back(lookup);
        row_name.push_back(name);
        row_pc.push_back(pc);
        row_flag.push_back(flag);
        row_addr.push_back(addr);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic model_resolve(input bp_types_pkg::pc_t pc, input logic taken,
                                 input bp_types_pkg::pc_t target);
        logic [7:0] idx;
        logic [7:0] ci;
        logic [5:0] bi;
        idx = pc[bp_geometry_pkg::idx_lsb +: bp_geometry_pkg::idx_width];
        bi = pc[bp_geometry_pkg::btb_idx_lsb +: bp_geometry_pkg::btb_idx_width];
        // counter picked by the history before the shift
        ci = m_hist[idx] ^ idx;
        if (taken && m_ctr[ci] != bp_types_pkg::ctr_strong_t)
            m_ctr[ci] = m_ctr[ci] + 2'd1;
        else if (!taken && m_ctr[ci] != bp_types_pkg::ctr_strong_nt)
            m_ctr[ci] = m_ctr[ci] - 2'd1;
        m_hist[idx] = {m_hist[idx][6:0], taken};
        if (taken) begin
            m_valid[bi] = 1'b1;
            m_branch[bi] = pc;
            m_target[bi] = target;
        end
    endtask

    task automatic model_predict(input bp_types_pkg::pc_t pc, output logic taken,
                                 output bp_types_pkg::pc_t next);
        logic [7:0] idx;
        logic [5:0] bi;
        logic hit;
        idx = pc[bp_geometry_pkg::idx_lsb +: bp_geometry_pkg::idx_width];
        bi = pc[bp_geometry_pkg::btb_idx_lsb +: bp_geometry_pkg::btb_idx_width];
        taken = m_ctr[m_hist[idx] ^ idx] >= bp_types_pkg::ctr_weak_t;
        hit = m_valid[bi] && (m_branch[bi][31:8] == pc[31:8]);
        next = (taken && hit) ? m_target[bi] : pc + 32'd4;
    endtask

    ////////////////////////////////////////////////////////////
    // drivers and collector
    ////////////////////////////////////////////////////////////

    // called at a drive point, returns at the next one
    task automatic send_lookup(input string name, input bp_types_pkg::pc_t pc,
                               input logic taken, input bp_types_pkg::pc_t next);
        req_valid = 1'b1;
        req_pc = pc;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        exp_name.push_back(name);
        exp_pc.push_back(pc);
        exp_taken.push_back(taken);
        exp_next.push_back(next);
        exp_cycle.push_back(cycle);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic apply_resolve(input bp_types_pkg::pc_t pc, input logic taken,
                                 input bp_types_pkg::pc_t target);
        update_valid = 1'b1;
        update_pc = pc;
        update_taken = taken;
        update_target = target;
        @(posedge clk);
        #1;
        update_valid = 1'b0;
        model_resolve(pc, taken, target);
    endtask

    task automatic wait_drained();
        do @(posedge clk); while (exp_pc.size() != 0);
        #1;
    endtask

    // in-order compare, latency only while pred_ready is held
    always @(negedge clk) begin : collect
        string name;
        if (!rst && pred_valid && pred_ready) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("prediction for %h arrived with no request outstanding", pred_pc);
            end else begin
                name = exp_name.pop_front();
                check_value({name, " pc"}, exp_pc.pop_front(), pred_pc);
                check_value({name, " taken"}, exp_taken.pop_front(), pred_taken);
                check_value({name, " next"}, exp_next.pop_front(), pred_next_pc);
                if (ready_held)
                    check_value({name, " latency"}, 32'd2, cycle - exp_cycle.pop_front());
                else
                    void'(exp_cycle.pop_front());
            end
        end
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles with %0d predictions outstanding",
                 limit_cycles, exp_pc.size());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        logic taken;
        bp_types_pkg::pc_t next;
        bp_types_pkg::pc_t pc;
        rst = 1'b1;
        req_valid = 1'b0;
        req_pc = '0;
        pred_ready = 1'b1;
        update_valid = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        update_target = '0;
        foreach (m_hist[i]) m_hist[i] = '0;
        foreach (m_ctr[i]) m_ctr[i] = bp_types_pkg::ctr_strong_nt;
        foreach (m_valid[i]) m_valid[i] = 1'b0;

        // reset state never predicts taken
        add_row(1, "reset a", pc_a, 0, pc_a + 4);
        add_row(1, "reset e", pc_e, 0, pc_e + 4);
        add_row(1, "reset high", 32'h8000_0ffc, 0, 32'h8000_1000);
        // eight taken outcomes leave history 0xff, counter 0x10 ^ 0xff
        repeat (8) add_row(0, "train a", pc_a, 1, tgt_a);
        add_row(1, "full history", pc_a, 0, pc_a + 4);
        add_row(0, "train a", pc_a, 1, tgt_a);
        add_row(1, "weak nt", pc_a, 0, pc_a + 4);
        add_row(0, "train a", pc_a, 1, tgt_a);
        add_row(1, "weak t", pc_a, 1, tgt_a);
        add_row(1, "btb alias", pc_b, 1, pc_b + 4);
        // top saturation, then walk down from e
        repeat (2) add_row(0, "train a", pc_a, 1, tgt_a);
        add_row(1, "strong t", pc_e, 1, pc_e + 4);
        add_row(0, "untrain e", pc_e, 0, 0);
        add_row(1, "first nt", pc_e, 1, pc_e + 4);
        add_row(0, "untrain e", pc_e, 0, 0);
        add_row(1, "second nt", pc_e, 0, pc_e + 4);
        // bottom saturation, one taken step stays below the flip
        repeat (2) add_row(0, "untrain e", pc_e, 0, 0);
        add_row(0, "train a", pc_a, 1, tgt_a);
        add_row(1, "floor e", pc_e, 0, pc_e + 4);
        add_row(1, "floor a", pc_a, 0, pc_a + 4);

        limit_cycles = (row_pc.size() + rand_resolves + rand_lookups + burst_len) * 20;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (row_pc[i]) begin
            if (row_lookup[i]) begin
                model_predict(row_pc[i], taken, next);
                check_value({row_name[i], " model taken"}, row_flag[i], taken);
                check_value({row_name[i], " model next"}, row_addr[i], next);
                send_lookup(row_name[i], row_pc[i], row_flag[i], row_addr[i]);
                wait_drained();
            end else begin
                apply_resolve(row_pc[i], row_flag[i], row_addr[i]);
            end
        end

        // back-to-back requests, two cycles each
        repeat (burst_len) begin
            addr_state = xorshift(addr_state);
            pc = addr_state & 32'h0000_0ffc;
            model_predict(pc, taken, next);
            send_lookup("burst", pc, taken, next);
        end
        wait_drained();

        // small address pool so tags and slots collide
        repeat (rand_resolves) begin
            addr_state = xorshift(addr_state);
            pc = addr_state & 32'h0000_0ffc;
            addr_state = xorshift(addr_state);
            apply_resolve(pc, addr_state[31], addr_state & 32'hffff_fffc);
        end
        ready_held = 1'b0;
        repeat (rand_lookups) begin
            addr_state = xorshift(addr_state);
            pc = addr_state & 32'h0000_0ffc;
            model_predict(pc, taken, next);
            send_lookup("random", pc, taken, next);
        end
        wait_drained();

        errors += dut.u_assertions.failures;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== project.f ====
src/bp_geometry_pkg.sv
src/bp_types_pkg.sv
src/pipe_stage_reg.sv
src/branch_history_table.sv
src/pattern_counter_table.sv
src/branch_target_buffer.sv
src/branch_predictor.sv
bench/branch_predictor_assertions.sv
bench/tb_branch_predictor.sv
